// File: rtl/sxt_defs.svh
/*
 * Sizes of the sample extraction stage
 * Polynomial length, bank count, modulus and field widths
 */

`ifndef SXT_DEFS_SVH
`define SXT_DEFS_SVH

// Polynomial and bank layout
`define SXT_N        16
`define SXT_R        4
`define SXT_WORD_NB  (`SXT_N / `SXT_R)

// Coefficient modulus, a prime just below 2^16
`define SXT_MOD_Q_W  16
`define SXT_MOD_Q    65521

// Body covers 0 .. 2N-1
`define SXT_BODY_W   5
// Index into the N coefficients
`define SXT_IDX_W    4
// Address inside one bank, N/R entries
`define SXT_ADD_W    2

`endif

// File: rtl/sxt_pkg.sv
/*
 * Shared types of the sample extraction stage
 * Coefficient, body, index and address vectors, FSM states
 */

`include "sxt_defs.svh"

package sxt_pkg;

  // --------------------
  // Data and command fields
  typedef logic [`SXT_MOD_Q_W-1:0] coef_t;
  typedef logic [`SXT_BODY_W-1:0]  body_t;
  typedef logic [`SXT_IDX_W-1:0]   coef_idx_t;

  // --------------------
  // Bank addressing
  typedef logic [`SXT_ADD_W-1:0]   bank_add_t;
  typedef logic [1:0]              bank_sel_t;
  typedef logic [1:0]              word_cnt_t;

  // Command FSM
  typedef enum logic {IDLE, RUN} sxt_state_e;

endpackage

// File: rtl/coef_bank.sv
/*
 * One coefficient RAM bank
 * N/R entries, one write port, registered read
 */

`timescale 1ns/1ps
`include "sxt_defs.svh"

module coef_bank
  import sxt_pkg::*;
(
  input  logic      clk,
  input  logic      rd_en,
  input  bank_add_t rd_add,
  input  logic      wr_en,
  input  bank_add_t wr_add,
  input  coef_t     wr_data,
  output coef_t     rd_data
);

  // Storage array
  coef_t mem [`SXT_WORD_NB];

  // Write in the sampling cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_add] <= wr_data;
    end
  end

  // Read data one cycle after the request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_add];
    end
  end

endmodule

// File: rtl/sxt_addr_gen.sv
/*
 * Command FSM and address generation
 * Decodes loads into reversed bank positions, issues one read per bank
 * per word and drives the lane control for the rotate/negate stage
 */

`timescale 1ns/1ps
`include "sxt_defs.svh"

module sxt_addr_gen
  import sxt_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_start,
  input  body_t                   cmd_body,
  input  logic                    load_en,
  input  coef_idx_t               load_idx,
  input  coef_t                   load_data,
  output logic                    busy,
  output logic      [`SXT_R-1:0]  bank_rd_en,
  output bank_add_t [`SXT_R-1:0]  bank_rd_add,
  output logic      [`SXT_R-1:0]  bank_wr_en,
  output bank_add_t               bank_wr_add,
  output coef_t                   bank_wr_data,
  output logic                    ctl_vld,
  output logic                    ctl_last,
  output bank_sel_t [`SXT_R-1:0]  ctl_bank_sel,
  output logic      [`SXT_R-1:0]  ctl_neg
);

  sxt_state_e state;
  body_t      body_q;
  word_cnt_t  word_cnt;
  logic       last_word;

  // Per-lane view of the current word
  body_t     [`SXT_R-1:0] lane_k;
  coef_idx_t [`SXT_R-1:0] lane_src;
  coef_idx_t [`SXT_R-1:0] lane_rev;
  logic      [`SXT_R-1:0] lane_neg;
  bank_sel_t [`SXT_R-1:0] lane_bank;
  bank_add_t [`SXT_R-1:0] lane_add;

  // Per-bank read request, before the output register
  logic      [`SXT_R-1:0] rd_en_nxt;
  bank_add_t [`SXT_R-1:0] rd_add_nxt;

  coef_idx_t load_rev;

  assign busy      = (state == RUN);
  assign last_word = (word_cnt == word_cnt_t'(`SXT_WORD_NB - 1));

  // --------------------
  // Command FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      word_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_start) begin
            state    <= RUN;
            word_cnt <= '0;
          end
        end
        RUN: begin
          // One word per cycle, back to idle after the last
          word_cnt <= word_cnt + 1'b1;
          if (last_word) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Body held for the whole command
  always_ff @(posedge clk) begin
    if (cmd_start && (state == IDLE)) begin
      body_q <= cmd_body;
    end
  end

  // --------------------
  // Lane mapping
  always_comb begin
    rd_en_nxt  = '0;
    rd_add_nxt = '0;
    for (int l = 0; l < `SXT_R; l++) begin
      // k = (i - b) mod 2N, wraps naturally in BODY_W bits
      lane_k[l]    = body_t'(int'(word_cnt) * `SXT_R + l - int'(body_q));
      lane_neg[l]  = (lane_k[l] >= body_t'(`SXT_N));
      // Low bits give k or k-N since N is a power of two
      lane_src[l]  = coef_idx_t'(lane_k[l]);
      // Stored in reverse order
      lane_rev[l]  = coef_idx_t'(`SXT_N - 1) - lane_src[l];
      lane_bank[l] = bank_sel_t'(lane_rev[l] % `SXT_R);
      lane_add[l]  = bank_add_t'(lane_rev[l] / `SXT_R);
    end
    // Route each lane address to the bank holding it
    for (int l = 0; l < `SXT_R; l++) begin
      rd_en_nxt[lane_bank[l]]  = busy;
      rd_add_nxt[lane_bank[l]] = lane_add[l];
    end
  end

  // --------------------
  // Registered read and lane control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_rd_en <= '0;
      ctl_vld    <= 1'b0;
      ctl_last   <= 1'b0;
    end else begin
      bank_rd_en <= rd_en_nxt;
      ctl_vld    <= busy;
      ctl_last   <= busy && last_word;
    end
  end

  always_ff @(posedge clk) begin
    bank_rd_add  <= rd_add_nxt;
    ctl_bank_sel <= lane_bank;
    ctl_neg      <= lane_neg;
  end

  // --------------------
  // Load path, same reversed mapping, written at once
  assign load_rev = coef_idx_t'(`SXT_N - 1) - load_idx;

  always_comb begin
    bank_wr_en = '0;
    bank_wr_en[bank_sel_t'(load_rev % `SXT_R)] = load_en;
  end

  assign bank_wr_add  = bank_add_t'(load_rev / `SXT_R);
  assign bank_wr_data = load_data;

  // Host must wait for busy low
  a_no_cmd_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !cmd_start);
  a_no_load_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !load_en);

endmodule

// File: rtl/sxt_rot_neg.sv
/*
 * Rotate and negate stage
 * Aligns lane control with bank data, picks a bank per lane,
 * applies the modular negation and registers the word
 */

`timescale 1ns/1ps
`include "sxt_defs.svh"

module sxt_rot_neg
  import sxt_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ctl_vld,
  input  logic                    ctl_last,
  input  bank_sel_t [`SXT_R-1:0]  ctl_bank_sel,
  input  logic      [`SXT_R-1:0]  ctl_neg,
  input  coef_t     [`SXT_R-1:0]  bank_rd_data,
  output logic                    out_vld,
  output logic                    out_last,
  output coef_t     [`SXT_R-1:0]  out_data
);

  // Control delayed to meet the bank data
  logic                   vld_d;
  logic                   last_d;
  bank_sel_t [`SXT_R-1:0] sel_d;
  logic      [`SXT_R-1:0] neg_d;

  coef_t [`SXT_R-1:0] lane_raw;
  coef_t [`SXT_R-1:0] lane_res;

  // --------------------
  // Control alignment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d  <= 1'b0;
      last_d <= 1'b0;
    end else begin
      vld_d  <= ctl_vld;
      last_d <= ctl_last;
    end
  end

  always_ff @(posedge clk) begin
    sel_d <= ctl_bank_sel;
    neg_d <= ctl_neg;
  end

  // --------------------
  // Lane routing and negation
  always_comb begin
    for (int l = 0; l < `SXT_R; l++) begin
      lane_raw[l] = bank_rd_data[sel_d[l]];
      // Zero stays zero, otherwise Q - x
      if (neg_d[l] && (lane_raw[l] != '0)) begin
        lane_res[l] = coef_t'(`SXT_MOD_Q) - lane_raw[l];
      end else begin
        lane_res[l] = lane_raw[l];
      end
    end
  end

  // --------------------
  // Output word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld  <= 1'b0;
      out_last <= 1'b0;
    end else begin
      out_vld  <= vld_d;
      out_last <= vld_d && last_d;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_d) begin
      out_data <= lane_res;
    end
  end

  // Loaded data below Q keeps every lane in range
  for (genvar l = 0; l < `SXT_R; l++) begin : g_lane_chk
    a_lane_below_q: assert property (@(posedge clk) disable iff (!rst_n)
      out_vld |-> (out_data[l] < coef_t'(`SXT_MOD_Q)));
  end

endmodule

// File: rtl/sample_extract_top.sv
/*
 * Sample extraction top
 * Address generator, coefficient banks and rotate/negate stage
 */

`timescale 1ns/1ps
`include "sxt_defs.svh"

module sample_extract_top
  import sxt_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_start,
  input  body_t                   cmd_body,
  input  logic                    load_en,
  input  coef_idx_t               load_idx,
  input  coef_t                   load_data,
  output logic                    busy,
  output logic                    out_vld,
  output logic                    out_last,
  output coef_t     [`SXT_R-1:0]  out_data
);

  // --------------------
  // Bank side
  logic      [`SXT_R-1:0] bank_rd_en;
  bank_add_t [`SXT_R-1:0] bank_rd_add;
  logic      [`SXT_R-1:0] bank_wr_en;
  bank_add_t              bank_wr_add;
  coef_t                  bank_wr_data;
  coef_t     [`SXT_R-1:0] bank_rd_data;

  // Lane control
  logic                   ctl_vld;
  logic                   ctl_last;
  bank_sel_t [`SXT_R-1:0] ctl_bank_sel;
  logic      [`SXT_R-1:0] ctl_neg;

  sxt_addr_gen u_addr_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_start    (cmd_start),
    .cmd_body     (cmd_body),
    .load_en      (load_en),
    .load_idx     (load_idx),
    .load_data    (load_data),
    .busy         (busy),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_add  (bank_rd_add),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_add  (bank_wr_add),
    .bank_wr_data (bank_wr_data),
    .ctl_vld      (ctl_vld),
    .ctl_last     (ctl_last),
    .ctl_bank_sel (ctl_bank_sel),
    .ctl_neg      (ctl_neg)
  );

  // One bank per lane position, write data shared
  for (genvar b = 0; b < `SXT_R; b++) begin : g_bank
    coef_bank u_coef_bank (
      .clk     (clk),
      .rd_en   (bank_rd_en[b]),
      .rd_add  (bank_rd_add[b]),
      .wr_en   (bank_wr_en[b]),
      .wr_add  (bank_wr_add),
      .wr_data (bank_wr_data),
      .rd_data (bank_rd_data[b])
    );
  end

  sxt_rot_neg u_rot_neg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl_vld      (ctl_vld),
    .ctl_last     (ctl_last),
    .ctl_bank_sel (ctl_bank_sel),
    .ctl_neg      (ctl_neg),
    .bank_rd_data (bank_rd_data),
    .out_vld      (out_vld),
    .out_last     (out_last),
    .out_data     (out_data)
  );

endmodule

// File: tests/tb_sample_extract.sv
/*
 * Testbench for the sample extraction top
 * Clock and reset, random loads and commands, reference model of the
 * negacyclic rotation, output monitor with fixed-latency checks
 */

`timescale 1ns/1ps
`include "sxt_defs.svh"

module tb_sample_extract
  import sxt_pkg::*;
;

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_start;
  body_t                   cmd_body;
  logic                    load_en;
  coef_idx_t               load_idx;
  coef_t                   load_data;
  logic                    busy;
  logic                    out_vld;
  logic                    out_last;
  coef_t     [`SXT_R-1:0]  out_data;

  // Reference copy of the coefficients, natural order
  int model [`SXT_N];

  // Expected words, pushed when a command is issued
  logic [`SXT_R*`SXT_MOD_Q_W-1:0] exp_data_q [$];
  int                             exp_cyc_q  [$];
  bit                             exp_last_q [$];

  int cyc;
  int words_seen;
  int cmds_issued;
  int mon_cyc;
  bit mon_last;
  logic [`SXT_R*`SXT_MOD_Q_W-1:0] mon_word;

  sample_extract_top u_sample_extract_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_body  (cmd_body),
    .load_en   (load_en),
    .load_idx  (load_idx),
    .load_data (load_data),
    .busy      (busy),
    .out_vld   (out_vld),
    .out_last  (out_last),
    .out_data  (out_data)
  );

  // --------------------
  // Clock and edge counter
  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------
  // Failure handling
  task automatic fail_and_stop();
    $display("Checks failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp_val,
                             input string what);
    if (got !== exp_val) begin
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp_val);
      fail_and_stop();
    end
  endtask

  // --------------------
  // Reference model
  function automatic int neg_mod(input int x);
    // Zero has no distinct negative
    if (x == 0) begin
      return 0;
    end
    return `SXT_MOD_Q - x;
  endfunction

  function automatic int rotated_coef(input int i, input int body);
    int k;
    k = ((i - body) % (2 * `SXT_N) + 2 * `SXT_N) % (2 * `SXT_N);
    if (k < `SXT_N) begin
      return model[k];
    end
    return neg_mod(model[k - `SXT_N]);
  endfunction

  task automatic push_expected(input int body, input int start_edge);
    logic [`SXT_R*`SXT_MOD_Q_W-1:0] word;
    for (int w = 0; w < `SXT_WORD_NB; w++) begin
      for (int l = 0; l < `SXT_R; l++) begin
        word[l*`SXT_MOD_Q_W +: `SXT_MOD_Q_W] = rotated_coef(w * `SXT_R + l, body);
      end
      exp_data_q.push_back(word);
      // Fixed latency, word w three edges after its read
      exp_cyc_q.push_back(start_edge + w + 3);
      exp_last_q.push_back(w == `SXT_WORD_NB - 1);
    end
  endtask

  // --------------------
  // Stimulus tasks, each starts and ends on a falling edge
  task automatic load_coef(input int idx, input int val);
    load_en   = 1'b1;
    load_idx  = coef_idx_t'(idx);
    load_data = coef_t'(val);
    model[idx] = val;
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic run_command(input int body);
    int start_edge;
    int t;
    cmd_start = 1'b1;
    cmd_body  = body_t'(body);
    start_edge = cyc + 1;
    push_expected(body, start_edge);
    cmds_issued++;
    @(negedge clk);
    cmd_start = 1'b0;
    check_value(busy, 1, "busy after command start");
    t = 0;
    while (busy && (t < 20)) begin
      @(negedge clk);
      t++;
    end
    if (busy) begin
      $display("Timeout: busy never fell after a command");
      fail_and_stop();
    end
    // Busy drops once word 3 is issued, before it reaches the output
    check_value(cyc, start_edge + 4, "edge where busy falls");
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    while ((exp_cyc_q.size() != 0) && (t < 50)) begin
      @(negedge clk);
      t++;
    end
    if (exp_cyc_q.size() != 0) begin
      $display("Timeout: no output word came for a pending command");
      fail_and_stop();
    end
  endtask

  // --------------------
  // Output monitor
  always @(negedge clk) begin
    if (rst_n && out_vld) begin
      if (exp_cyc_q.size() == 0) begin
        $display("Output word appeared with no command pending");
        fail_and_stop();
      end else begin
        mon_word = exp_data_q.pop_front();
        mon_cyc  = exp_cyc_q.pop_front();
        mon_last = exp_last_q.pop_front();
        check_value(cyc, mon_cyc, "output word edge");
        for (int l = 0; l < `SXT_R; l++) begin
          check_value(out_data[l], mon_word[l*`SXT_MOD_Q_W +: `SXT_MOD_Q_W],
                      $sformatf("lane %0d data", l));
        end
        check_value(out_last, mon_last, "out_last flag");
        words_seen++;
      end
    end
  end

  // --------------------
  // Main sequence
  initial begin
    int n_reload;
    void'($urandom(32'h470b_2c11));
    cyc         = 0;
    words_seen  = 0;
    cmds_issued = 0;
    rst_n       = 1'b0;
    cmd_start   = 1'b0;
    cmd_body    = '0;
    load_en     = 1'b0;
    load_idx    = '0;
    load_data   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value(busy, 0, "busy after reset");
    check_value(out_vld, 0, "out_vld after reset");
    check_value(out_last, 0, "out_last after reset");

    // Natural order with body 0
    for (int c = 0; c < `SXT_N; c++) begin
      load_coef(c, $urandom % `SXT_MOD_Q);
    end
    run_command(0);
    wait_drained();

    // Random bodies, small random gaps
    for (int n = 0; n < 40; n++) begin
      run_command($urandom % (2 * `SXT_N));
      repeat ($urandom % 3) @(negedge clk);
    end
    wait_drained();

    // Upper half bodies, one zero coefficient
    load_coef($urandom % `SXT_N, 0);
    // Body N negates every lane, the zero one included
    run_command(`SXT_N);
    for (int n = 0; n < 12; n++) begin
      run_command(`SXT_N + ($urandom % `SXT_N));
    end
    wait_drained();

    // Strictly back to back
    for (int n = 0; n < 8; n++) begin
      run_command($urandom % (2 * `SXT_N));
    end
    wait_drained();

    // Reloads between commands, some with words still in flight
    for (int n = 0; n < 10; n++) begin
      n_reload = 1 + ($urandom % 3);
      for (int r = 0; r < n_reload; r++) begin
        load_coef($urandom % `SXT_N, $urandom % `SXT_MOD_Q);
      end
      run_command($urandom % (2 * `SXT_N));
    end
    wait_drained();

    repeat (4) @(negedge clk);
    if ((exp_cyc_q.size() == 0) && (words_seen == cmds_issued * `SXT_WORD_NB)) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Word count mismatch, %0d words for %0d commands", words_seen, cmds_issued);
      fail_and_stop();
    end
  end

endmodule

// File: sample_extract.f
+incdir+rtl
rtl/sxt_pkg.sv
rtl/coef_bank.sv
rtl/sxt_addr_gen.sv
rtl/sxt_rot_neg.sv
rtl/sample_extract_top.sv
tests/tb_sample_extract.sv

// File: Bender.yml
package:
  name: sample_extract

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/sxt_pkg.sv
      - rtl/coef_bank.sv
      - rtl/sxt_addr_gen.sv
      - rtl/sxt_rot_neg.sv
      - rtl/sample_extract_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_sample_extract.sv
